//--- filelist.f
+incdir+common
common/pipeline_pkg.sv
branch_predictor/branch_predictor.sv
reorder_buffer/reorder_buffer.sv
verilog/pipeline_core.sv
tests/tb_clock.sv
tests/pipeline_core_assertions.sv
tests/pipeline_core_tb.sv

//--- Bender.yml
package:
  name: pipeline_core

sources:
  - include_dirs:
      - common
    files:
      - common/pipeline_pkg.sv
      - branch_predictor/branch_predictor.sv
      - reorder_buffer/reorder_buffer.sv
      - verilog/pipeline_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_clock.sv
      - tests/pipeline_core_assertions.sv
      - tests/pipeline_core_tb.sv

//--- tests/pipeline_core_tb.sv
`timescale 1ns/1ps
`include "pipeline_config.svh"

module pipeline_core_tb;
    import pipeline_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;   // Well above the total test length
    localparam int PRED_ENTRIES   = 1 << `PRED_INDEX_BITS;

    logic     clk;
    logic     rst_n;
    xlen_t    fetch_pc;
    logic     resolve_valid;
    xlen_t    resolve_pc;
    logic     resolve_taken;
    xlen_t    resolve_target;
    logic     pred_hit;
    logic     pred_taken;
    xlen_t    pred_target;
    logic     alloc_valid;
    xlen_t    alloc_pc;
    reg_idx_t alloc_rd;
    logic     wb_valid;
    rob_tag_t wb_tag;
    xlen_t    wb_result;
    logic     commit_ready;
    logic     alloc_full;
    rob_tag_t alloc_tag;
    logic     rob_empty;
    logic     commit_valid;
    xlen_t    commit_pc;
    reg_idx_t commit_rd;
    xlen_t    commit_result;

    // Predictor model with counters kept as 0..3
    logic  m_valid [PRED_ENTRIES];
    xlen_t m_tag   [PRED_ENTRIES];
    int    m_cnt   [PRED_ENTRIES];
    xlen_t m_tgt   [PRED_ENTRIES];

    // Reorder buffer model
    xlen_t    r_pc    [`ROB_DEPTH];
    reg_idx_t r_rd    [`ROB_DEPTH];
    xlen_t    r_res   [`ROB_DEPTH];
    logic     r_ready [`ROB_DEPTH];
    rob_tag_t order_q [$];           // Tags in allocation order
    rob_tag_t r_tail;

    logic [15:0] lfsr;
    int          checks;
    int          errors;
    int          commits;
    int          cycles;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    pipeline_core UUT (.*);

    bind pipeline_core pipeline_core_assertions u_assertions (
        .clk(clk), .rst_n(rst_n), .alloc_full(alloc_full), .rob_empty(rob_empty),
        .commit_valid(commit_valid), .commit_ready(commit_ready),
        .commit_pc(commit_pc), .commit_rd(commit_rd), .commit_result(commit_result)
    );

    // ==================================================
    // Helpers
    // ==================================================

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[15]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int pred_index(xlen_t pc);
        return int'(pc[`PRED_INDEX_BITS+1:2]);
    endfunction

    function automatic xlen_t pred_tag(xlen_t pc);
        return pc >> (`PRED_INDEX_BITS + 2);
    endfunction

    function automatic int total_errors();
        return errors + int'(UUT.u_assertions.fail_count);
    endfunction

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("[FAIL] time %0d ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int start);
        if (total_errors() == start) begin
            $display("Test %0d %s: passed", num, name);
        end else begin
            $display("Test %0d %s: %0d errors", num, name, total_errors() - start);
        end
    endtask

    task automatic resolve(input xlen_t pc, input logic taken, input xlen_t target);
        int i;
        i = pred_index(pc);
        @(posedge clk);
        resolve_valid  <= 1'b1;
        resolve_pc     <= pc;
        resolve_taken  <= taken;
        resolve_target <= target;
        @(posedge clk);
        resolve_valid  <= 1'b0;
        if (m_valid[i] && m_tag[i] == pred_tag(pc)) begin
            if (taken && m_cnt[i] < 3) m_cnt[i]++;          // Saturate high
            else if (!taken && m_cnt[i] > 0) m_cnt[i]--;    // Saturate low
        end else begin
            m_valid[i] = 1'b1;
            m_tag[i]   = pred_tag(pc);
            m_cnt[i]   = taken ? 2 : 1;
        end
        m_tgt[i] = target;
    endtask

    task automatic lookup(input xlen_t pc);
        int    i;
        logic  hit;
        logic  taken;
        xlen_t target;
        i      = pred_index(pc);
        hit    = m_valid[i] && (m_tag[i] == pred_tag(pc));
        taken  = hit && (m_cnt[i] >= 2);
        target = hit ? m_tgt[i] : pc + 64'd4;
        @(posedge clk);
        fetch_pc <= pc;
        @(negedge clk);
        check(pred_hit === hit && pred_taken === taken && pred_target === target,
              $sformatf("lookup %h gave hit %b taken %b target %h, expected %b %b %h",
                        pc, pred_hit, pred_taken, pred_target, hit, taken, target));
    endtask

    task automatic alloc(input xlen_t pc, input reg_idx_t rd);
        logic full;
        full = (order_q.size() == `ROB_DEPTH);
        @(posedge clk);
        alloc_valid <= 1'b1;
        alloc_pc    <= pc;
        alloc_rd    <= rd;
        @(negedge clk);
        if (!full) begin
            check(alloc_tag === r_tail,
                  $sformatf("alloc_tag %0d, expected %0d", alloc_tag, r_tail));
        end
        @(posedge clk);
        alloc_valid <= 1'b0;
        if (!full) begin
            r_pc[r_tail]    = pc;
            r_rd[r_tail]    = rd;
            r_ready[r_tail] = 1'b0;
            order_q.push_back(r_tail);
            r_tail = (r_tail == `ROB_DEPTH - 1) ? '0 : r_tail + 1'b1;
        end
    endtask

    task automatic writeback(input rob_tag_t tag, input xlen_t value);
        @(posedge clk);
        wb_valid  <= 1'b1;
        wb_tag    <= tag;
        wb_result <= value;
        @(posedge clk);
        wb_valid  <= 1'b0;
        r_res[tag]   = value;
        r_ready[tag] = 1'b1;
    endtask

    // ==================================================
    // Commit monitor and timeout
    // ==================================================

    // Sampled mid-cycle so a handshake seen here retires on the next edge
    always @(negedge clk) begin : commit_monitor
        rob_tag_t head;
        logic     exp_valid;
        if (rst_n) begin
            exp_valid = (order_q.size() != 0) && r_ready[order_q[0]];
            check(rob_empty === (order_q.size() == 0),
                  $sformatf("rob_empty %b with %0d entries", rob_empty, order_q.size()));
            check(alloc_full === (order_q.size() == `ROB_DEPTH),
                  $sformatf("alloc_full %b with %0d entries", alloc_full, order_q.size()));
            check(commit_valid === exp_valid,
                  $sformatf("commit_valid %b, expected %b", commit_valid, exp_valid));
            if (exp_valid) begin
                head = order_q[0];
                check(commit_pc === r_pc[head] && commit_rd === r_rd[head]
                      && commit_result === r_res[head],
                      $sformatf("commit pc %h rd %0d result %h, expected %h %0d %h",
                                commit_pc, commit_rd, commit_result,
                                r_pc[head], r_rd[head], r_res[head]));
                if (commit_ready) begin
                    void'(order_q.pop_front());
                end
            end
            if (commit_valid === 1'b1 && commit_ready) begin
                commits++;                      // Handshakes seen on the DUT
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // ==================================================
    // Tests
    // ==================================================

    initial begin
        xlen_t       pc_a;
        xlen_t       pc_b;
        logic [63:0] bits;
        rob_tag_t    tags [`ROB_DEPTH];
        rob_tag_t    tmp;
        int          j;
        int          start;
        int          base;

        fetch_pc       = '0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        alloc_valid    = 1'b0;
        alloc_pc       = '0;
        alloc_rd       = '0;
        wb_valid       = 1'b0;
        wb_tag         = '0;
        wb_result      = '0;
        commit_ready   = 1'b0;
        for (int i = 0; i < PRED_ENTRIES; i++) m_valid[i] = 1'b0;
        r_tail  = '0;
        lfsr    = 16'd74;
        checks  = 0;
        errors  = 0;
        commits = 0;
        cycles  = 0;
        pc_a    = 64'h0000_0000_0000_1040;
        pc_b    = pc_a + (64'd1 << (`PRED_INDEX_BITS + 2));  // Same index but a new tag

        wait (rst_n === 1'b1);

        start = total_errors();
        lookup(64'h0000_0000_0000_1000);
        lookup(64'h0000_0000_0000_2004);
        lookup(64'hffff_0000_0000_0040);
        lookup(64'h0000_0000_0000_0008);
        report_test(1, "lookups after reset", start);

        start = total_errors();
        resolve(pc_a, 1'b1, 64'h2000);
        lookup(pc_a);
        resolve(pc_a, 1'b0, 64'h2000);
        lookup(pc_a);                          // Weak not taken
        resolve(pc_a, 1'b1, 64'h2000);
        resolve(pc_a, 1'b1, 64'h2000);
        resolve(pc_a, 1'b0, 64'h2000);
        lookup(pc_a);
        report_test(2, "counter training", start);

        start = total_errors();
        lookup(pc_b);
        resolve(pc_b, 1'b1, 64'h3000);
        lookup(pc_b);
        lookup(pc_a);                          // Evicted
        report_test(3, "tag conflict", start);

        start = total_errors();
        base  = commits;
        @(posedge clk);
        commit_ready <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            tags[i] = r_tail;
            take_bits(`REG_BITS, bits);
            alloc(64'h4000 + 64'(4 * i), bits[`REG_BITS-1:0]);
        end
        for (int i = 5; i > 0; i--) begin
            take_bits(3, bits);
            j       = int'(bits[2:0]) % (i + 1);
            tmp     = tags[i];
            tags[i] = tags[j];
            tags[j] = tmp;
        end
        for (int i = 0; i < 6; i++) begin
            take_bits(`XLEN, bits);
            writeback(tags[i], bits);
        end
        @(negedge clk);
        while (rob_empty !== 1'b1) @(negedge clk);
        check(commits - base == 6, $sformatf("%0d commits, expected 6", commits - base));
        report_test(4, "out-of-order writeback", start);

        start = total_errors();
        base  = commits;
        @(posedge clk);
        commit_ready <= 1'b0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            tags[i] = r_tail;
            take_bits(`REG_BITS, bits);
            alloc(64'h8000 + 64'(4 * i), bits[`REG_BITS-1:0]);
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            take_bits(`XLEN, bits);
            writeback(tags[i], bits);
        end
        alloc(64'h9000, 1);                    // Dropped while full
        repeat (4) @(posedge clk);
        commit_ready <= 1'b1;
        @(negedge clk);
        while (rob_empty !== 1'b1) @(negedge clk);
        check(commits - base == `ROB_DEPTH,
              $sformatf("%0d commits, expected %0d", commits - base, `ROB_DEPTH));
        report_test(5, "full buffer and drain", start);

        $display("Summary: 5 tests, %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, UUT.u_assertions.fail_count);
        if (total_errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tests/pipeline_core_assertions.sv
`timescale 1ns/1ps

module pipeline_core_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   alloc_full,
    input logic                   rob_empty,
    input logic                   commit_valid,
    input logic                   commit_ready,
    input pipeline_pkg::xlen_t    commit_pc,
    input pipeline_pkg::reg_idx_t commit_rd,
    input pipeline_pkg::xlen_t    commit_result
);

    int unsigned fail_count = 0;    // Read by the testbench at the end

    // ==================================================
    // Occupancy flags
    // ==================================================

    a_commit_not_empty: assert property (
        @(posedge clk) disable iff (!rst_n) commit_valid |-> !rob_empty
    ) else begin
        $error("commit_valid is high while the buffer reports empty");
        fail_count++;
    end

    a_full_not_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !(alloc_full && rob_empty)
    ) else begin
        $error("alloc_full and rob_empty are high together");
        fail_count++;
    end

    // ==================================================
    // Commit back-pressure
    // ==================================================

    // Head must hold while the consumer stalls
    a_commit_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (commit_valid && !commit_ready) |=>
            (commit_valid && $stable(commit_pc) && $stable(commit_rd)
             && $stable(commit_result))
    ) else begin
        $error("commit outputs changed while commit_ready was low");
        fail_count++;
    end

    a_reset_state: assert property (
        @(posedge clk) $rose(rst_n) |-> (rob_empty && !commit_valid)
    ) else begin
        $error("buffer not empty or commit_valid high right after reset");
        fail_count++;
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 4;    // 8 ns period

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset low for the first 3 cycles
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- verilog/pipeline_core.sv
`timescale 1ns/1ps

module pipeline_core (
    input  logic                   clk,
    input  logic                   rst_n,
    // Predictor lookup and resolution
    input  pipeline_pkg::xlen_t    fetch_pc,
    input  logic                   resolve_valid,
    input  pipeline_pkg::xlen_t    resolve_pc,
    input  logic                   resolve_taken,
    input  pipeline_pkg::xlen_t    resolve_target,
    output logic                   pred_hit,
    output logic                   pred_taken,
    output pipeline_pkg::xlen_t    pred_target,
    // Reorder buffer
    input  logic                   alloc_valid,
    input  pipeline_pkg::xlen_t    alloc_pc,
    input  pipeline_pkg::reg_idx_t alloc_rd,
    input  logic                   wb_valid,
    input  pipeline_pkg::rob_tag_t wb_tag,
    input  pipeline_pkg::xlen_t    wb_result,
    input  logic                   commit_ready,
    output logic                   alloc_full,
    output pipeline_pkg::rob_tag_t alloc_tag,
    output logic                   rob_empty,
    output logic                   commit_valid,
    output pipeline_pkg::xlen_t    commit_pc,
    output pipeline_pkg::reg_idx_t commit_rd,
    output pipeline_pkg::xlen_t    commit_result
);

    // ==================================================
    // Front end prediction
    // ==================================================

    branch_predictor u_branch_predictor (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_pc       (fetch_pc),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .pred_hit       (pred_hit),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target)
    );

    // ==================================================
    // In-order retirement
    // ==================================================

    reorder_buffer u_reorder_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_valid   (alloc_valid),
        .alloc_pc      (alloc_pc),
        .alloc_rd      (alloc_rd),
        .wb_valid      (wb_valid),
        .wb_tag        (wb_tag),
        .wb_result     (wb_result),
        .commit_ready  (commit_ready),
        .alloc_full    (alloc_full),
        .alloc_tag     (alloc_tag),
        .rob_empty     (rob_empty),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_rd     (commit_rd),
        .commit_result (commit_result)
    );

endmodule

//--- reorder_buffer/reorder_buffer.sv
`timescale 1ns/1ps
`include "pipeline_config.svh"

module reorder_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    // Allocation, program order
    input  logic                   alloc_valid,
    input  pipeline_pkg::xlen_t    alloc_pc,
    input  pipeline_pkg::reg_idx_t alloc_rd,
    // Writeback, any order
    input  logic                   wb_valid,
    input  pipeline_pkg::rob_tag_t wb_tag,
    input  pipeline_pkg::xlen_t    wb_result,
    // Commit back-pressure
    input  logic                   commit_ready,
    output logic                   alloc_full,
    output pipeline_pkg::rob_tag_t alloc_tag,
    output logic                   rob_empty,
    output logic                   commit_valid,
    output pipeline_pkg::xlen_t    commit_pc,
    output pipeline_pkg::reg_idx_t commit_rd,
    output pipeline_pkg::xlen_t    commit_result
);
    import pipeline_pkg::*;

    localparam logic [`ROB_TAG_BITS:0] FULL_COUNT = `ROB_DEPTH;

    rob_entry_t entries [`ROB_DEPTH];

    rob_tag_t                head;    // Oldest entry
    rob_tag_t                tail;    // Next free slot
    logic [`ROB_TAG_BITS:0]  count;   // One extra bit so every slot is usable
    rob_entry_t              head_entry;
    logic                    do_alloc;
    logic                    do_commit;

    // Wrap at the depth, works for any depth
    function automatic rob_tag_t ptr_inc(rob_tag_t ptr);
        rob_tag_t nxt;
        if (ptr == rob_tag_t'(`ROB_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // ==================================================
    // Status and handshakes
    // ==================================================

    assign alloc_full = (count == FULL_COUNT);
    assign rob_empty  = (count == '0);
    assign alloc_tag  = tail;                   // Slot granted this cycle
    assign do_alloc   = alloc_valid && !alloc_full;

    // Only the head may retire
    assign head_entry    = entries[head];
    assign commit_valid  = head_entry.valid && head_entry.ready;
    assign commit_pc     = head_entry.pc;
    assign commit_rd     = head_entry.rd;
    assign commit_result = head_entry.result;
    assign do_commit     = commit_valid && commit_ready;

    // ==================================================
    // Pointers and occupancy
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_alloc) begin
                tail <= ptr_inc(tail);
            end
            if (do_commit) begin
                head <= ptr_inc(head);
            end
            case ({do_alloc, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    // ==================================================
    // Entry storage
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            if (do_alloc) begin
                entries[tail].valid <= 1'b1;
                entries[tail].ready <= 1'b0;
                entries[tail].pc    <= alloc_pc;
                entries[tail].rd    <= alloc_rd;
            end
            // Writeback by tag, ignored on a free slot
            if (wb_valid && entries[wb_tag].valid) begin
                entries[wb_tag].ready  <= 1'b1;
                entries[wb_tag].result <= wb_result;
            end
            if (do_commit) begin
                entries[head].valid <= 1'b0;
            end
        end
    end

endmodule

//--- branch_predictor/branch_predictor.sv
`timescale 1ns/1ps
`include "pipeline_config.svh"

module branch_predictor (
    input  logic                clk,
    input  logic                rst_n,
    // Lookup
    input  pipeline_pkg::xlen_t fetch_pc,
    // Resolution from execute
    input  logic                resolve_valid,
    input  pipeline_pkg::xlen_t resolve_pc,
    input  logic                resolve_taken,
    input  pipeline_pkg::xlen_t resolve_target,
    // Prediction
    output logic                pred_hit,
    output logic                pred_taken,
    output pipeline_pkg::xlen_t pred_target
);
    import pipeline_pkg::*;

    localparam int ENTRIES = 1 << `PRED_INDEX_BITS;
    localparam int TAG_LSB = `PRED_INDEX_BITS + 2;    // Skip byte offset

    pred_entry_t pred_table [ENTRIES];

    logic [`PRED_INDEX_BITS-1:0] fetch_idx;
    logic [`PRED_INDEX_BITS-1:0] resolve_idx;
    logic [`XLEN-TAG_LSB-1:0]    fetch_tag;
    logic [`XLEN-TAG_LSB-1:0]    resolve_tag;
    pred_entry_t                 fetch_entry;
    pred_entry_t                 resolve_entry;
    logic [1:0]                  fetch_cnt;
    logic                        resolve_hit;
    pred_entry_t                 new_entry;

    // Saturating update, taken counts up
    function automatic pred_counter_t train(pred_counter_t cnt, logic taken);
        pred_counter_t nxt;
        case (cnt)
            strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   nxt = taken ? weak_taken     : strong_not_taken;
            weak_taken:       nxt = taken ? strong_taken   : weak_not_taken;
            strong_taken:     nxt = taken ? strong_taken   : weak_taken;
            default:          nxt = cnt;
        endcase
        return nxt;
    endfunction

    // ==================================================
    // Lookup, zero cycle
    // ==================================================

    assign fetch_idx   = fetch_pc[TAG_LSB-1:2];
    assign fetch_tag   = fetch_pc[`XLEN-1:TAG_LSB];
    assign fetch_entry = pred_table[fetch_idx];
    assign fetch_cnt   = fetch_entry.counter;

    assign pred_hit    = fetch_entry.valid && (fetch_entry.tag == fetch_tag);
    assign pred_taken  = pred_hit && fetch_cnt[1];
    assign pred_target = pred_hit ? fetch_entry.target : fetch_pc + xlen_t'(4);  // Fall-through

    // ==================================================
    // Training on resolution
    // ==================================================

    assign resolve_idx   = resolve_pc[TAG_LSB-1:2];
    assign resolve_tag   = resolve_pc[`XLEN-1:TAG_LSB];
    assign resolve_entry = pred_table[resolve_idx];
    assign resolve_hit   = resolve_entry.valid && (resolve_entry.tag == resolve_tag);

    always_comb begin
        new_entry.valid  = 1'b1;
        new_entry.tag    = resolve_tag;
        new_entry.target = resolve_target;    // Refreshed on hit too
        if (resolve_hit) begin
            new_entry.counter = train(resolve_entry.counter, resolve_taken);
        end else begin
            // Fresh slot starts weak in the resolved direction
            new_entry.counter = resolve_taken ? weak_taken : weak_not_taken;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pred_table[i].valid <= 1'b0;
            end
        end else if (resolve_valid) begin
            pred_table[resolve_idx] <= new_entry;   // Train or replace
        end
    end

endmodule

//--- common/pipeline_pkg.sv
`include "pipeline_config.svh"

package pipeline_pkg;

    // ==================================================
    // Scalar types
    // ==================================================

    typedef logic [`XLEN-1:0]         xlen_t;     // Data word or PC
    typedef logic [`REG_BITS-1:0]     reg_idx_t;  // Destination register
    typedef logic [`ROB_TAG_BITS-1:0] rob_tag_t;  // Reorder buffer slot

    // 2-bit saturating counter, upper bit is the prediction
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } pred_counter_t;

    // ==================================================
    // Table entries
    // ==================================================

    // Tag is everything above the index and the byte offset
    typedef struct packed {
        logic                                valid;
        logic [`XLEN-`PRED_INDEX_BITS-3:0]   tag;
        xlen_t                               target;   // Last resolved target
        pred_counter_t                       counter;
    } pred_entry_t;

    typedef struct packed {
        logic     valid;    // Slot allocated
        logic     ready;    // Result written back
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    result;
    } rob_entry_t;

endpackage

//--- common/pipeline_config.svh
`ifndef PIPELINE_CONFIG_SVH
`define PIPELINE_CONFIG_SVH

// ==================================================
// Datapath widths
// ==================================================

`define XLEN             64     // Data word and PC
`define REG_BITS         6      // Architectural register index

// ==================================================
// Branch predictor
// ==================================================

`define PRED_INDEX_BITS  6      // 64 table slots

// ==================================================
// Reorder buffer
// ==================================================

`define ROB_DEPTH        16
`define ROB_TAG_BITS     4      // log2 of ROB_DEPTH

`endif
